/* hw/sccb_pkg.sv */
package sccb_pkg;

	// SCCB bus constants
	localparam logic [7:0] SCCB_DEV_ID = 8'h42;
	localparam int STEP_DIV = 21;
	localparam int WRITE_STEPS = 87;
	// device id, register address and value, nine bits each
	localparam int FRAME_BITS = 27;
	localparam int STEP_W = $clog2(WRITE_STEPS);
	localparam int DIV_W = $clog2(STEP_DIV);

	// 200 ms at 10 MHz
	localparam int SETTLE_CYCLES_DEFAULT = 2000000;
	localparam logic [7:0] SOFT_RESET_REG = 8'h12;
	localparam int SOFT_RESET_BIT = 7;

	// register map
	localparam logic [3:0] ADDR_CMD = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;

	typedef struct packed {
		logic [7:0] reg_addr;
		logic [7:0] reg_data;
	} sccb_cmd_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic busy;
		logic settling;
		logic [7:0] done_count;
	} sccb_status_t;

endpackage

/* hw/sccb_apb_decode.sv */
`timescale 1ns/1ps

module sccb_apb_decode (
	input  logic                m10ck,
	input  logic                rstsw_i,
	input  sccb_pkg::apb_req_t  apb_i,
	input  logic                cmd_ready_i,
	input  logic                done_i,
	input  logic                busy_i,
	input  logic                hold_i,
	output sccb_pkg::apb_rsp_t  apb_o,
	output sccb_pkg::sccb_cmd_t cmd_o,
	output logic                cmd_valid_o
);

	logic access;
	logic is_cmd_wr;
	logic is_status_rd;
	logic cmd_accept;
	logic hold_full;
	sccb_pkg::sccb_cmd_t hold_cmd;
	logic [7:0] done_count;
	sccb_pkg::sccb_status_t status;

	assign access = apb_i.psel && apb_i.penable;
	assign is_cmd_wr = apb_i.pwrite && (apb_i.paddr == sccb_pkg::ADDR_CMD);
	assign is_status_rd = !apb_i.pwrite && (apb_i.paddr == sccb_pkg::ADDR_STATUS);

	// a command write only completes once the holding register is free
	assign cmd_accept = access && is_cmd_wr && !hold_full;

	always_comb begin
		status.busy = busy_i;
		status.settling = hold_i;
		status.done_count = done_count;
	end

	always_comb begin
		apb_o.prdata = '0;
		apb_o.pready = 1'b0;
		apb_o.pslverr = 1'b0;
		if (access) begin
			if (is_cmd_wr) begin
				apb_o.pready = !hold_full;
			end else if (is_status_rd) begin
				apb_o.pready = 1'b1;
				apb_o.prdata = 32'(status);
			end else begin
				// unmapped address or wrong direction
				apb_o.pready = 1'b1;
				apb_o.pslverr = 1'b1;
			end
		end
	end

	// one-entry holding register
	always_ff @(posedge m10ck) begin
		if (!rstsw_i) begin
			hold_full <= 1'b0;
		end else begin
			if (cmd_accept) begin
				hold_full <= 1'b1;
			end else if (hold_full && cmd_ready_i) begin
				hold_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge m10ck) begin
		if (cmd_accept) begin
			hold_cmd <= sccb_pkg::sccb_cmd_t'(apb_i.pwdata[15:0]);
		end
	end

	assign cmd_o = hold_cmd;
	assign cmd_valid_o = hold_full;

	// completed writes, wraps at 256
	always_ff @(posedge m10ck) begin
		if (!rstsw_i) begin
			done_count <= '0;
		end else if (done_i) begin
			done_count <= done_count + 8'd1;
		end
	end

endmodule

/* hw/sccb_write_sequencer.sv */
`timescale 1ns/1ps

module sccb_write_sequencer (
	input  logic                m10ck,
	input  logic                rstsw_i,
	input  sccb_pkg::sccb_cmd_t cmd_i,
	input  logic                cmd_valid_i,
	input  logic                hold_i,
	output logic                cmd_ready_o,
	output logic                busy_o,
	output logic                done_o,
	output sccb_pkg::sccb_cmd_t done_cmd_o,
	output logic                scl_o,
	output logic                sda_o
);

	logic busy;
	logic done;
	logic start;
	logic scl;
	logic sda;
	logic [sccb_pkg::STEP_W-1:0] step;
	logic [sccb_pkg::STEP_W-1:0] step_nxt;
	logic [sccb_pkg::DIV_W-1:0] div;
	logic [sccb_pkg::FRAME_BITS-1:0] frame;
	sccb_pkg::sccb_cmd_t cur_cmd;

	// {scl, sda} for a given step of the write
	function automatic logic [1:0] bus_level(
		input logic [sccb_pkg::STEP_W-1:0] s,
		input logic [sccb_pkg::FRAME_BITS-1:0] fr
	);
		int st;
		int idx;
		int ph;
		logic [1:0] lvl;
		st = int'(s);
		idx = (st - 2) / 3;
		ph = (st - 2) % 3;
		if (st == 0) begin
			lvl = 2'b11;
		end else if (st == 1) begin
			// start: sda falls under a high scl
			lvl = 2'b10;
		end else if (st < sccb_pkg::WRITE_STEPS - 4) begin
			// data setup with scl low, then one scl high step, then scl low
			lvl = {ph == 1, fr[sccb_pkg::FRAME_BITS - 1 - idx]};
		end else if (st == sccb_pkg::WRITE_STEPS - 4) begin
			lvl = {1'b0, fr[0]};
		end else if (st == sccb_pkg::WRITE_STEPS - 3) begin
			lvl = 2'b00;
		end else if (st == sccb_pkg::WRITE_STEPS - 2) begin
			lvl = 2'b10;
		end else begin
			// stop: sda rises under a high scl
			lvl = 2'b11;
		end
		return lvl;
	endfunction

	// ninth bit of every frame left high
	assign frame = {sccb_pkg::SCCB_DEV_ID, 1'b1, cur_cmd.reg_addr, 1'b1,
		cur_cmd.reg_data, 1'b1};

	// no new command in the done cycle, so the settle hold is seen in time
	assign cmd_ready_o = !busy && !done && !hold_i;
	assign start = cmd_valid_i && cmd_ready_o;
	assign step_nxt = step + 1'b1;

	always_ff @(posedge m10ck) begin
		if (!rstsw_i) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
			div <= '0;
			scl <= 1'b1;
			sda <= 1'b1;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
				div <= '0;
				scl <= 1'b1;
				sda <= 1'b1;
			end else if (busy) begin
				if (int'(div) == sccb_pkg::STEP_DIV - 1) begin
					div <= '0;
					if (int'(step) == sccb_pkg::WRITE_STEPS - 1) begin
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						step <= step_nxt;
						{scl, sda} <= bus_level(step_nxt, frame);
					end
				end else begin
					div <= div + 1'b1;
				end
			end
		end
	end

	// command payload
	always_ff @(posedge m10ck) begin
		if (start) begin
			cur_cmd <= cmd_i;
		end
	end

	assign busy_o = busy;
	assign done_o = done;
	assign done_cmd_o = cur_cmd;
	assign scl_o = scl;
	assign sda_o = sda;

endmodule

/* hw/sccb_settle_timer.sv */
`timescale 1ns/1ps

module sccb_settle_timer #(
	parameter int SETTLE_CYCLES = sccb_pkg::SETTLE_CYCLES_DEFAULT
) (
	input  logic                m10ck,
	input  logic                rstsw_i,
	input  logic                done_i,
	input  sccb_pkg::sccb_cmd_t done_cmd_i,
	output logic                hold_o
);

	typedef logic [$clog2(SETTLE_CYCLES + 1)-1:0] settle_cnt_t;

	logic soft_reset;
	settle_cnt_t cnt;

	// register 0x12 with the reset bit set
	assign soft_reset = (done_cmd_i.reg_addr == sccb_pkg::SOFT_RESET_REG) &&
		done_cmd_i.reg_data[sccb_pkg::SOFT_RESET_BIT];

	always_ff @(posedge m10ck) begin
		if (!rstsw_i) begin
			cnt <= '0;
		end else begin
			if (done_i && soft_reset) begin
				cnt <= settle_cnt_t'(SETTLE_CYCLES);
			end else if (cnt != '0) begin
				cnt <= cnt - settle_cnt_t'(1);
			end
		end
	end

	// high for SETTLE_CYCLES cycles after the done pulse
	assign hold_o = (cnt != '0);

endmodule

/* hw/sccb_master_top.sv */
`timescale 1ns/1ps

module sccb_master_top #(
	parameter int SETTLE_CYCLES = sccb_pkg::SETTLE_CYCLES_DEFAULT
) (
	input  logic               m10ck,
	input  logic               rstsw_i,
	input  sccb_pkg::apb_req_t apb_i,
	output sccb_pkg::apb_rsp_t apb_o,
	output logic               scl_o,
	output logic               sda_o
);

	sccb_pkg::sccb_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	logic busy;
	logic done;
	sccb_pkg::sccb_cmd_t done_cmd;
	logic hold;

	// APB port and holding register
	sccb_apb_decode i_sccb_apb_decode (
		.m10ck       (m10ck),
		.rstsw_i     (rstsw_i),
		.apb_i       (apb_i),
		.cmd_ready_i (cmd_ready),
		.done_i      (done),
		.busy_i      (busy),
		.hold_i      (hold),
		.apb_o       (apb_o),
		.cmd_o       (cmd),
		.cmd_valid_o (cmd_valid)
	);

	// bit sequencer
	sccb_write_sequencer i_sccb_write_sequencer (
		.m10ck       (m10ck),
		.rstsw_i     (rstsw_i),
		.cmd_i       (cmd),
		.cmd_valid_i (cmd_valid),
		.hold_i      (hold),
		.cmd_ready_o (cmd_ready),
		.busy_o      (busy),
		.done_o      (done),
		.done_cmd_o  (done_cmd),
		.scl_o       (scl_o),
		.sda_o       (sda_o)
	);

	// pause after a sensor soft reset
	sccb_settle_timer #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) i_sccb_settle_timer (
		.m10ck      (m10ck),
		.rstsw_i    (rstsw_i),
		.done_i     (done),
		.done_cmd_i (done_cmd),
		.hold_o     (hold)
	);

endmodule

/* tb/sccb_master_sva.sv */
`timescale 1ns/1ps

module sccb_master_sva (
	input logic               m10ck,
	input logic               rstsw_i,
	input sccb_pkg::apb_req_t apb_i,
	input sccb_pkg::apb_rsp_t apb_rsp_i,
	input logic               scl_i,
	input logic               sda_i,
	input logic               busy_i
);

	logic apb_pending;
	int fail_count;

	// setup phase, or an access phase that is still waiting
	assign apb_pending = apb_i.psel && (!apb_i.penable || !apb_rsp_i.pready);

	apb_stable: assert property (@(posedge m10ck) disable iff (!rstsw_i)
		apb_pending |=> $stable(apb_i.paddr) && $stable(apb_i.pwdata))
		else begin
			$error("APB address or write data changed during a transfer");
			fail_count++;
		end

	sda_on_scl_edge: assert property (@(posedge m10ck) disable iff (!rstsw_i)
		$changed(scl_i) |-> $stable(sda_i))
		else begin
			$error("sda changed together with scl");
			fail_count++;
		end

	// sda moving under a high scl is a start or a stop and only happens inside a write
	start_stop_in_write: assert property (@(posedge m10ck) disable iff (!rstsw_i)
		(scl_i && $past(scl_i) && $changed(sda_i)) |-> busy_i)
		else begin
			$error("sda changed while scl was high outside a write");
			fail_count++;
		end

	bus_idle_after_reset: assert property (@(posedge m10ck)
		$rose(rstsw_i) |-> scl_i && sda_i)
		else begin
			$error("scl or sda low in the cycle after reset");
			fail_count++;
		end

endmodule

/* tb/tb_sccb_master.sv */
`timescale 1ns/1ps

module tb_sccb_master;

	localparam int SETTLE_CYCLES = 500;
	localparam int WRITE_CYCLES = sccb_pkg::WRITE_STEPS * sccb_pkg::STEP_DIV;

	logic m10ck;
	logic rstsw_i;
	sccb_pkg::apb_req_t apb_req;
	sccb_pkg::apb_rsp_t apb_rsp;
	logic scl;
	logic sda;

	logic [7:0] op_q[$];
	logic [3:0] addr_q[$];
	logic [31:0] wdata_q[$];
	logic slverr_q[$];
	logic [31:0] rdata_q[$];
	int case_count;
	bit cases_loaded;
	logic [23:0] expect_q[$];
	logic [23:0] exp_bytes;
	int pushed_count;
	int decoded_count;
	int cycle;
	int seed;
	bit stall_seen;
	logic prev_scl;
	logic prev_sda;
	int bit_cnt;
	logic [23:0] shift;
	bit settle_armed;
	int stop_cycle;

	sccb_master_top #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) i_sccb_master_top (
		.m10ck   (m10ck),
		.rstsw_i (rstsw_i),
		.apb_i   (apb_req),
		.apb_o   (apb_rsp),
		.scl_o   (scl),
		.sda_o   (sda)
	);

	bind sccb_master_top sccb_master_sva i_sccb_master_sva (
		.m10ck     (m10ck),
		.rstsw_i   (rstsw_i),
		.apb_i     (apb_i),
		.apb_rsp_i (apb_o),
		.scl_i     (scl_o),
		.sda_i     (sda_o),
		.busy_i    (busy)
	);

	initial begin
		m10ck = 1'b0;
		forever #5 m10ck = ~m10ck;
	end

	always @(posedge m10ck) begin
		cycle <= cycle + 1;
	end

	task automatic abort_run;
		$display("Done: errors found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic load_cases;
		int fd;
		int c;
		int n;
		logic [3:0] addr;
		logic [31:0] wdata;
		logic slverr;
		logic [31:0] rdata;
		fd = $fopen("tb/sccb_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the cases file tb/sccb_cases.txt");
			abort_run();
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				while (c != -1 && c != "\n") begin
					c = $fgetc(fd);
				end
			end else if (c == "W" || c == "R" || c == "D") begin
				n = $fscanf(fd, " %h %h %h %h", addr, wdata, slverr, rdata);
				if (n != 4) begin
					$display("malformed line in the cases file after case %0d", op_q.size());
					abort_run();
				end
				op_q.push_back(8'(c));
				addr_q.push_back(addr);
				wdata_q.push_back(wdata);
				slverr_q.push_back(slverr);
				rdata_q.push_back(rdata);
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		case_count = op_q.size();
	endtask

	task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic slverr, output int waits);
		@(posedge m10ck);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge m10ck);
		apb_req.penable <= 1'b1;
		waits = 0;
		@(negedge m10ck);
		while (!apb_rsp.pready) begin
			waits++;
			@(negedge m10ck);
		end
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge m10ck);
		apb_req <= '0;
	endtask

	// all written commands out on the bus, then poll until the sequencer is idle
	task automatic drain_bus;
		logic [31:0] rdata;
		logic slverr;
		int waits;
		sccb_pkg::sccb_status_t status;
		wait (decoded_count == pushed_count);
		status = '0;
		status.busy = 1'b1;
		while (status.busy) begin
			apb_transfer(1'b0, sccb_pkg::ADDR_STATUS, 32'h0, rdata, slverr, waits);
			status = sccb_pkg::sccb_status_t'(rdata[9:0]);
		end
	endtask

	// SCCB bus decoder
	always @(negedge m10ck) begin
		if (rstsw_i !== 1'b1) begin
			prev_scl = 1'b1;
			prev_sda = 1'b1;
			bit_cnt = 0;
		end else begin
			if (prev_scl && scl && prev_sda && !sda) begin
				bit_cnt = 0;
				shift = '0;
				if (settle_armed) begin
					settle_armed = 1'b0;
					assert (cycle - stop_cycle >= SETTLE_CYCLES) else begin
						$display("mismatch at %0t: start %0d cycles after soft reset stop",
							$time, cycle - stop_cycle);
						abort_run();
					end
				end
			end else if (prev_scl && scl && !prev_sda && sda) begin
				// 27 frame bits and the scl rise ahead of stop
				assert (bit_cnt == 28 && expect_q.size() > 0) else begin
					$display("unexpected bus transaction with %0d scl pulses", bit_cnt);
					abort_run();
				end
				exp_bytes = expect_q.pop_front();
				assert (shift === exp_bytes) else begin
					$display("mismatch at %0t: bus bytes %h, expected %h", $time, shift, exp_bytes);
					abort_run();
				end
				decoded_count++;
				if (shift[15:8] == sccb_pkg::SOFT_RESET_REG &&
					shift[sccb_pkg::SOFT_RESET_BIT]) begin
					settle_armed = 1'b1;
					stop_cycle = cycle;
				end
			end else if (!prev_scl && scl) begin
				// only the first eight bits of each frame are kept
				if (bit_cnt < 27 && bit_cnt % 9 != 8) begin
					shift = {shift[22:0], sda};
				end
				bit_cnt++;
			end
			prev_scl = scl;
			prev_sda = sda;
		end
	end

	initial begin
		wait (cases_loaded);
		repeat (case_count * (WRITE_CYCLES + SETTLE_CYCLES) * 2) @(posedge m10ck);
		$display("timeout: the cases did not complete in time");
		abort_run();
	end

	initial begin
		wait (i_sccb_master_top.i_sccb_master_sva.fail_count != 0);
		$display("a protocol assertion on the APB or SCCB bus failed");
		abort_run();
	end

	initial begin
		int i;
		int idle;
		int waits;
		logic [31:0] rdata;
		logic slverr;
		logic is_cmd_wr;
		rstsw_i = 1'b0;
		apb_req = '0;
		seed = 45759;
		load_cases();
		cases_loaded = 1'b1;
		repeat (3) @(posedge m10ck);
		rstsw_i <= 1'b1;
		@(negedge m10ck);
		assert (scl === 1'b1 && sda === 1'b1) else begin
			$display("mismatch at %0t: bus not idle after reset, scl %b sda %b", $time, scl, sda);
			abort_run();
		end
		for (i = 0; i < case_count; i++) begin
			if (op_q[i] == "D") begin
				drain_bus();
			end else begin
				is_cmd_wr = (op_q[i] == "W") && (addr_q[i] == sccb_pkg::ADDR_CMD);
				apb_transfer(op_q[i] == "W", addr_q[i], wdata_q[i], rdata, slverr, waits);
				assert (slverr === slverr_q[i] && (op_q[i] == "W" || rdata === rdata_q[i])) else begin
					$display("mismatch at %0t: case %0d got pslverr %b prdata %h, expected %b %h",
						$time, i, slverr, rdata, slverr_q[i], rdata_q[i]);
					abort_run();
				end
				if (is_cmd_wr) begin
					if (waits > 0) begin
						stall_seen = 1'b1;
					end
					expect_q.push_back({sccb_pkg::SCCB_DEV_ID, wdata_q[i][15:0]});
					pushed_count++;
				end else begin
					assert (waits == 0) else begin
						$display("mismatch at %0t: case %0d took %0d wait states", $time, i, waits);
						abort_run();
					end
				end
			end
			idle = {$random(seed)} % 4;
			repeat (idle) @(posedge m10ck);
		end
		assert (stall_seen) else begin
			$display("no command write was ever held off by a full holding register");
			abort_run();
		end
		assert (expect_q.size() == 0 && decoded_count == pushed_count) else begin
			$display("%0d commands written but %0d seen on the bus", pushed_count, decoded_count);
			abort_run();
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

/* files.f */
hw/sccb_pkg.sv
hw/sccb_apb_decode.sv
hw/sccb_write_sequencer.sv
hw/sccb_settle_timer.sv
hw/sccb_master_top.sv
tb/sccb_master_sva.sv
tb/tb_sccb_master.sv

/* tb/sccb_cases.txt */
# op paddr pwdata exp_pslverr exp_prdata, all hex
# W write, R read, D wait until the bus has drained (other columns unused)
R 4 00000000 0 00000000
W 0 00001234 0 00000000
W 0 00005678 0 00000000
W 0 00009abc 0 00000000
D 0 00000000 0 00000000
R 4 00000000 0 00000003
W 0 00001280 0 00000000
D 0 00000000 0 00000000
R 4 00000000 0 00000104
W 0 00000a5a 0 00000000
W 8 0000ffff 1 00000000
R 0 00000000 1 00000000
W 4 00000000 1 00000000
R c 00000000 1 00000000
D 0 00000000 0 00000000
R 4 00000000 0 00000005
W 0 00001200 0 00000000
W 0 00003c3c 0 00000000
W 0 0000ff01 0 00000000
D 0 00000000 0 00000000
R 4 00000000 0 00000008
